//--- p4_router_ingress.f
+incdir+.
p4_ingress_pkg.sv
p4_ingress_width_adapt.sv
p4_ingress_port_buf.sv
p4_ingress_arb_mux.sv
p4_router_ingress.sv
tb_p4_router_ingress.sv

//--- Makefile
# Verilator build and run of the ingress subsystem testbench

TOP   = tb_p4_router_ingress
FLIST = p4_router_ingress.f

.PHONY: all run lint clean

all: run

obj_dir/sim: $(FLIST) $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f $(FLIST) -o sim

run: obj_dir/sim
	-./obj_dir/sim > sim.log 2>&1
	@cat sim.log
	@grep -q "^Result: PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module p4_router_ingress -f $(FLIST)

clean:
	rm -rf obj_dir sim.log

//--- tb_p4_router_ingress.sv
/* Self-checking testbench for the ingress subsystem. Stimulus comes from one LFSR
   and the reference model packs the same bytes eight per converged beat. */

`timescale 1ns/1ns
`include "p4_ingress_defs.svh"

module tb_p4_router_ingress
    import p4_ingress_pkg::*;
();

    localparam int nport      = `P4_ING_NUM_PORTS;
    localparam int clk_period = 8;
    localparam int rounds     = 6;
    // Round robin, random traffic rounds and the overflow pair
    localparam int num_pkts   = 6 + rounds * 18 + 2;
    // Longest packet in input cycles, the oversized one on an 8-bit port
    localparam int max_len    = 160;

    logic         clk;
    logic         rst_n;
    logic         drv_valid [nport];
    logic [31:0]  drv_data  [nport];
    logic [3:0]   drv_keep  [nport];
    logic         drv_last  [nport];

    logic         out_tvalid;
    logic         out_tready;
    p4_beat_u     out_tdata;
    p4_keep_t     out_tkeep;
    logic         out_tlast;
    p4_port_idx_t out_tuser;
    logic [nport-1:0] ing_buf_overflow;

    logic [31:0]  lfsr = 32'd28;
    int           ready_mode = 0;
    logic         ready_pat [256];
    int           ready_idx = 0;

    // Pending stimulus and expected beats, one queue per port
    logic [7:0]   stim_byte [nport][$];
    int           stim_len  [nport][$];
    int           stim_gap  [nport][$];
    p4_beat_u     exp_data  [nport][$];
    p4_keep_t     exp_keep  [nport][$];
    logic         exp_last  [nport][$];

    p4_port_idx_t pkt_order [$];
    p4_port_idx_t cur_port = '0;
    logic         in_pkt = 1'b0;
    int           ovf_count [nport];
    int           ovf_base  [nport];

    p4_router_ingress DUT (
        .clk              ( clk                          ),
        .rst_n            ( rst_n                        ),
        .ing_8b_tvalid    ( {drv_valid[1], drv_valid[0]} ),
        .ing_8b_tdata     ( {drv_data[1][7:0], drv_data[0][7:0]} ),
        .ing_8b_tlast     ( {drv_last[1], drv_last[0]}   ),
        .ing_32b_tvalid   ( drv_valid[2]                 ),
        .ing_32b_tdata    ( drv_data[2]                  ),
        .ing_32b_tkeep    ( drv_keep[2]                  ),
        .ing_32b_tlast    ( drv_last[2]                  ),
        .out_tvalid       ( out_tvalid                   ),
        .out_tready       ( out_tready                   ),
        .out_tdata        ( out_tdata                    ),
        .out_tkeep        ( out_tkeep                    ),
        .out_tlast        ( out_tlast                    ),
        .out_tuser        ( out_tuser                    ),
        .ing_buf_overflow ( ing_buf_overflow             )
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic report_mismatch(input string msg);
        stop_run($sformatf("Error at %0t ns: %s", $time, msg));
    endtask

    task automatic check_beat(input p4_beat_u got_d, input p4_keep_t got_k, input logic got_l,
                              input p4_beat_u exp_d, input p4_keep_t exp_k, input logic exp_l);
        // Bytes outside keep carry no meaning
        for (int i = 0; i < `P4_ING_BUS_BYTES; i++) begin
            if (exp_k[i] && got_d.bytes[i] !== exp_d.bytes[i]) begin
                report_mismatch($sformatf("byte lane %0d is %h, expected %h",
                                          i, got_d.bytes[i], exp_d.bytes[i]));
            end
        end
        if (got_k !== exp_k) begin
            report_mismatch($sformatf("tkeep is %h, expected %h", got_k, exp_k));
        end
        if (got_l !== exp_l) begin
            report_mismatch($sformatf("tlast is %b, expected %b", got_l, exp_l));
        end
    endtask

    task automatic check_port(input p4_port_idx_t got, input p4_port_idx_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: port %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_overflow(input logic [nport-1:0] got, input logic [nport-1:0] exp,
                                  input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: overflow %b, expected %b", what, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Random numbers and reference model

    function automatic logic lfsr_step();
        logic bit_out;
        bit_out = lfsr[0];
        lfsr = lfsr >> 1;
        if (bit_out) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return bit_out;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_step());
        end
        return v;
    endfunction

    // Queues one packet for a port, and its beats for the model when it should arrive
    function automatic void add_packet(input int p, input int len, input int gap,
                                       input bit to_model);
        logic [7:0] b;
        p4_beat_u   d;
        p4_keep_t   k;
        int         n;
        n = 0;
        d = '0;
        k = '0;
        for (int i = 0; i < len; i++) begin
            b = 8'(rand_bits(8));
            stim_byte[p].push_back(b);
            d.bytes[n] = b;
            k[n] = 1'b1;
            n = n + 1;
            if (n == `P4_ING_BUS_BYTES || i == len - 1) begin
                if (to_model) begin
                    exp_data[p].push_back(d);
                    exp_keep[p].push_back(k);
                    exp_last[p].push_back(i == len - 1);
                end
                n = 0;
                d = '0;
                k = '0;
            end
        end
        stim_len[p].push_back(len);
        stim_gap[p].push_back(gap);
    endfunction

    function automatic int pending_beats();
        int total;
        total = 0;
        for (int i = 0; i < nport; i++) begin
            total = total + exp_data[i].size();
        end
        return total;
    endfunction

    function automatic void mark_overflow();
        for (int i = 0; i < nport; i++) begin
            ovf_base[i] = ovf_count[i];
        end
    endfunction

    function automatic logic [nport-1:0] ovf_changed();
        logic [nport-1:0] v;
        for (int i = 0; i < nport; i++) begin
            v[i] = (ovf_count[i] != ovf_base[i]);
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Port drivers, all changes on the falling edge

    task automatic drive_port(input int p);
        int          len;
        int          gap;
        logic [31:0] w;
        logic [3:0]  kp;
        while (stim_len[p].size() > 0) begin
            len = stim_len[p].pop_front();
            gap = stim_gap[p].pop_front();
            repeat (gap) @(negedge clk);
            if (p < `P4_ING_NUM_8B_PORTS) begin
                for (int i = 0; i < len; i++) begin
                    @(negedge clk);
                    drv_valid[p] = 1'b1;
                    drv_data[p]  = {24'h0, stim_byte[p].pop_front()};
                    drv_keep[p]  = 4'h1;
                    drv_last[p]  = (i == len - 1);
                end
            end else begin
                for (int i = 0; i < (len + 3) / 4; i++) begin
                    kp = '0;
                    // Filler past the end of the packet
                    w  = 32'hEEEE_EEEE;
                    for (int j = 0; j < 4; j++) begin
                        if (i * 4 + j < len) begin
                            w[j*8 +: 8] = stim_byte[p].pop_front();
                            kp[j] = 1'b1;
                        end
                    end
                    @(negedge clk);
                    drv_valid[p] = 1'b1;
                    drv_data[p]  = w;
                    drv_keep[p]  = kp;
                    drv_last[p]  = (i == (len + 3) / 4 - 1);
                end
            end
            @(negedge clk);
            drv_valid[p] = 1'b0;
            drv_last[p]  = 1'b0;
        end
    endtask

    initial begin : drive_ready
        out_tready = 1'b0;
        forever begin
            @(negedge clk);
            if (ready_mode == 0) begin
                out_tready = 1'b0;
            end else if (ready_mode == 1) begin
                out_tready = 1'b1;
            end else begin
                out_tready = ready_pat[ready_idx];
                ready_idx = (ready_idx + 1) % 256;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output monitor

    always @(posedge clk) begin : monitor
        int p;
        if (rst_n) begin
            for (int i = 0; i < nport; i++) begin
                if (ing_buf_overflow[i]) begin
                    ovf_count[i] = ovf_count[i] + 1;
                end
            end
            if (out_tvalid && out_tready) begin
                if (!in_pkt) begin
                    cur_port = out_tuser;
                end
                check_port(out_tuser, cur_port, "tuser changed inside a packet");
                p = int'(out_tuser);
                if (p >= nport || exp_data[p].size() == 0) begin
                    report_mismatch($sformatf("unexpected beat from port %0d", p));
                end else begin
                    check_beat(out_tdata, out_tkeep, out_tlast, exp_data[p].pop_front(),
                               exp_keep[p].pop_front(), exp_last[p].pop_front());
                    in_pkt = !out_tlast;
                    if (out_tlast) begin
                        pkt_order.push_back(out_tuser);
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequences

    task automatic wait_drain();
        while (pending_beats() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    // One short packet per port, all committed in the same cycle
    task automatic run_round_robin();
        int base;
        base = pkt_order.size();
        ready_mode = 0;
        add_packet(0, 4, 0, 1);
        add_packet(1, 4, 0, 1);
        add_packet(2, 16, 0, 1);
        fork
            drive_port(0);
            drive_port(1);
            drive_port(2);
        join
        while (!out_tvalid) @(posedge clk);
        ready_mode = 1;
        wait_drain();
        if (pkt_order.size() != base + 3) begin
            stop_run("Round robin step did not deliver exactly three packets");
        end
        for (int i = 0; i < nport; i++) begin
            check_port(pkt_order[base + i], p4_port_idx_t'(i), "round-robin order");
        end
    endtask

    // Two packets per port and round keep every buffer at 16 beats or less
    task automatic run_traffic(input logic [nport-1:0] ports, input int mode, input string what);
        ready_mode = mode;
        mark_overflow();
        for (int r = 0; r < rounds; r++) begin
            for (int p = 0; p < nport; p++) begin
                if (ports[p]) begin
                    add_packet(p, 1 + rand_bits(6), rand_bits(2), 1);
                    add_packet(p, 1 + rand_bits(6), rand_bits(2), 1);
                end
            end
            fork
                drive_port(0);
                drive_port(1);
                drive_port(2);
            join
            wait_drain();
        end
        check_overflow(ovf_changed(), '0, what);
    endtask

    task automatic run_overflow();
        logic [nport-1:0] exp_ovf;
        exp_ovf    = '0;
        exp_ovf[0] = 1'b1;
        ready_mode = 0;
        mark_overflow();
        // Longer than the whole buffer, so it is never delivered
        add_packet(0, 129 + rand_bits(5), 0, 0);
        add_packet(0, 1 + rand_bits(5), 2, 1);
        drive_port(0);
        while (!out_tvalid) @(posedge clk);
        check_overflow(ovf_changed(), exp_ovf, "oversized packet on port 0");
        if (ovf_count[0] - ovf_base[0] != 1) begin
            stop_run("Overflow on port 0 did not pulse for exactly one cycle");
        end
        ready_mode = 1;
        wait_drain();
    endtask

    initial begin : watchdog
        #(num_pkts * max_len * 20 * clk_period);
        stop_run("Timeout: the tests did not finish in the allowed time");
    end

    initial begin : main
        rst_n = 1'b0;
        for (int i = 0; i < nport; i++) begin
            drv_valid[i] = 1'b0;
            drv_data[i]  = '0;
            drv_keep[i]  = '0;
            drv_last[i]  = 1'b0;
        end
        for (int i = 0; i < 256; i++) begin
            ready_pat[i] = lfsr_step();
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);

        // Needs the reset value of the last grant, so it runs first
        run_round_robin();
        run_round_robin();
        run_traffic(3'b011, 1, "8-bit packing");
        run_traffic(3'b100, 1, "32-bit tail keep");
        run_traffic(3'b111, 1, "all ports");
        run_overflow();
        run_traffic(3'b111, 2, "back-pressure");

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- p4_router_ingress.sv
/* Ingress top for two 8-bit ports and one 32-bit port on a single clock.
   Physical ports have no ready, so a full buffer drops packets and flags overflow. */

`timescale 1ns/1ns
`include "p4_ingress_defs.svh"

module p4_router_ingress
    import p4_ingress_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst_n,

    input  logic [`P4_ING_NUM_8B_PORTS-1:0]       ing_8b_tvalid,
    input  logic [`P4_ING_NUM_8B_PORTS-1:0][7:0]  ing_8b_tdata,
    input  logic [`P4_ING_NUM_8B_PORTS-1:0]       ing_8b_tlast,

    input  logic [`P4_ING_NUM_32B_PORTS-1:0]      ing_32b_tvalid,
    input  logic [`P4_ING_NUM_32B_PORTS-1:0][31:0] ing_32b_tdata,
    input  logic [`P4_ING_NUM_32B_PORTS-1:0][3:0] ing_32b_tkeep,
    input  logic [`P4_ING_NUM_32B_PORTS-1:0]      ing_32b_tlast,

    output logic                                  out_tvalid,
    input  logic                                  out_tready,
    output p4_beat_u                              out_tdata,
    output p4_keep_t                              out_tkeep,
    output logic                                  out_tlast,
    output p4_port_idx_t                          out_tuser,

    output logic [`P4_ING_NUM_PORTS-1:0]          ing_buf_overflow
);

    localparam int n8    = `P4_ING_NUM_8B_PORTS;
    localparam int n32   = `P4_ING_NUM_32B_PORTS;
    localparam int nport = `P4_ING_NUM_PORTS;

    // Adapter outputs
    logic [nport-1:0] adp_valid;
    p4_beat_u         adp_data [nport];
    p4_keep_t         adp_keep [nport];
    logic [nport-1:0] adp_last;

    // Buffer read side
    logic [nport-1:0] buf_valid;
    logic [nport-1:0] buf_ready;
    p4_beat_u         buf_data [nport];
    p4_keep_t         buf_keep [nport];
    logic [nport-1:0] buf_last;

    //////////////////////////////////////////////////////////////////////
    // Width adapters, 8-bit ports first

    for (genvar i = 0; i < n8; i++) begin : g_adapt_8b
        p4_ingress_width_adapt #(
            .in_bytes   ( 1 )
        ) u_adapt (
            .clk        ( clk              ),
            .rst_n      ( rst_n            ),
            .in_valid   ( ing_8b_tvalid[i] ),
            .in_data    ( ing_8b_tdata[i]  ),
            .in_keep    ( 1'b1             ),
            .in_last    ( ing_8b_tlast[i]  ),
            .beat_valid ( adp_valid[i]     ),
            .beat_data  ( adp_data[i]      ),
            .beat_keep  ( adp_keep[i]      ),
            .beat_last  ( adp_last[i]      )
        );
    end

    for (genvar j = 0; j < n32; j++) begin : g_adapt_32b
        p4_ingress_width_adapt #(
            .in_bytes   ( 4 )
        ) u_adapt (
            .clk        ( clk                ),
            .rst_n      ( rst_n              ),
            .in_valid   ( ing_32b_tvalid[j]  ),
            .in_data    ( ing_32b_tdata[j]   ),
            .in_keep    ( ing_32b_tkeep[j]   ),
            .in_last    ( ing_32b_tlast[j]   ),
            .beat_valid ( adp_valid[n8+j]    ),
            .beat_data  ( adp_data[n8+j]     ),
            .beat_keep  ( adp_keep[n8+j]     ),
            .beat_last  ( adp_last[n8+j]     )
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Per-port packet buffers

    for (genvar p = 0; p < nport; p++) begin : g_buf
        p4_ingress_port_buf u_buf (
            .clk        ( clk                 ),
            .rst_n      ( rst_n               ),
            .beat_valid ( adp_valid[p]        ),
            .beat_data  ( adp_data[p]         ),
            .beat_keep  ( adp_keep[p]         ),
            .beat_last  ( adp_last[p]         ),
            .rd_valid   ( buf_valid[p]        ),
            .rd_ready   ( buf_ready[p]        ),
            .rd_data    ( buf_data[p]         ),
            .rd_keep    ( buf_keep[p]         ),
            .rd_last    ( buf_last[p]         ),
            .overflow   ( ing_buf_overflow[p] )
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Merge onto the converged bus

    p4_ingress_arb_mux u_arb_mux (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .in_valid   ( buf_valid  ),
        .in_data    ( buf_data   ),
        .in_keep    ( buf_keep   ),
        .in_last    ( buf_last   ),
        .in_ready   ( buf_ready  ),
        .out_tvalid ( out_tvalid ),
        .out_tready ( out_tready ),
        .out_tdata  ( out_tdata  ),
        .out_tkeep  ( out_tkeep  ),
        .out_tlast  ( out_tlast  ),
        .out_tuser  ( out_tuser  )
    );

endmodule

//--- p4_ingress_arb_mux.sv
/* Round-robin merge of whole packets onto the converged bus. An idle arbiter spends
   one cycle registering a grant, and tuser carries the granted port index. */

`timescale 1ns/1ns
`include "p4_ingress_defs.svh"

module p4_ingress_arb_mux
    import p4_ingress_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic [`P4_ING_NUM_PORTS-1:0] in_valid,
    input  p4_beat_u                     in_data [`P4_ING_NUM_PORTS],
    input  p4_keep_t                     in_keep [`P4_ING_NUM_PORTS],
    input  logic [`P4_ING_NUM_PORTS-1:0] in_last,
    output logic [`P4_ING_NUM_PORTS-1:0] in_ready,

    output logic                         out_tvalid,
    input  logic                         out_tready,
    output p4_beat_u                     out_tdata,
    output p4_keep_t                     out_tkeep,
    output logic                         out_tlast,
    output p4_port_idx_t                 out_tuser
);

    localparam int num_ports = `P4_ING_NUM_PORTS;

    // The grant register doubles as the last grant while idle
    p4_port_idx_t grant;
    p4_port_idx_t nxt_grant;
    logic         busy;
    logic         any_valid;

    //////////////////////////////////////////////////////////////////////
    // Next grant, first valid port after the last one

    always_comb begin
        int idx;
        nxt_grant = grant;
        // Walk from the far end so the nearest valid port wins
        for (int k = num_ports; k >= 1; k--) begin
            idx = (int'(grant) + k) % num_ports;
            if (in_valid[idx]) begin
                nxt_grant = p4_port_idx_t'(idx);
            end
        end
    end

    assign any_valid = |in_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            grant <= p4_port_idx_t'(num_ports - 1);
        end else if (!busy) begin
            if (any_valid) begin
                grant <= nxt_grant;
                busy  <= 1'b1;
            end
        end else if (out_tvalid && out_tready && out_tlast) begin
            busy <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output mux

    assign out_tvalid = busy && in_valid[grant];
    assign out_tdata  = in_data[grant];
    assign out_tkeep  = in_keep[grant];
    assign out_tlast  = in_last[grant];
    assign out_tuser  = grant;

    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            in_ready[i] = busy && out_tready && (grant == p4_port_idx_t'(i));
        end
    end

    a_tuser_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_tvalid && out_tready && !out_tlast |=> out_tuser == $past(out_tuser));

    // Buffers only release committed packets, so a packet never stalls midway
    a_no_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        out_tvalid && out_tready && !out_tlast |=> out_tvalid);

endmodule

//--- p4_ingress_port_buf.sv
/* Whole-packet buffer of P4_ING_BUF_DEPTH converged beats. A packet that does not
   fit is dropped entirely and never becomes readable. */

`timescale 1ns/1ns
`include "p4_ingress_defs.svh"

module p4_ingress_port_buf
    import p4_ingress_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     beat_valid,
    input  p4_beat_u beat_data,
    input  p4_keep_t beat_keep,
    input  logic     beat_last,

    output logic     rd_valid,
    input  logic     rd_ready,
    output p4_beat_u rd_data,
    output p4_keep_t rd_keep,
    output logic     rd_last,

    output logic     overflow
);

    localparam int depth = `P4_ING_BUF_DEPTH;
    localparam int aw    = $clog2(depth);

    p4_beat_u mem_data [depth];
    p4_keep_t mem_keep [depth];
    logic     mem_last [depth];

    // One extra bit on each pointer tells full from empty
    logic [aw:0] wr_ptr;
    logic [aw:0] cm_ptr;
    logic [aw:0] rd_ptr;
    logic [aw:0] fill;
    logic [aw:0] cm_fill;

    logic        full;
    logic        dropping;
    logic        wr_en;
    logic        drop_beat;
    logic        drop_last;

    assign fill      = wr_ptr - rd_ptr;
    assign cm_fill   = cm_ptr - rd_ptr;
    assign full      = (fill == (aw+1)'(depth));

    assign wr_en     = beat_valid && !dropping && !full;
    assign drop_beat = beat_valid && (dropping || full);
    assign drop_last = drop_beat && beat_last;

    //////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr[aw-1:0]] <= beat_data;
            mem_keep[wr_ptr[aw-1:0]] <= beat_keep;
            mem_last[wr_ptr[aw-1:0]] <= beat_last;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and drop control

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            cm_ptr   <= '0;
            rd_ptr   <= '0;
            dropping <= 1'b0;
            overflow <= 1'b0;
        end else begin
            overflow <= drop_last;

            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                // Packet is complete and goes to the read side
                if (beat_last) begin
                    cm_ptr <= wr_ptr + 1'b1;
                end
            end else if (drop_last) begin
                // Forget the partial packet
                wr_ptr <= cm_ptr;
            end

            if (drop_last) begin
                dropping <= 1'b0;
            end else if (drop_beat) begin
                dropping <= 1'b1;
            end

            if (rd_valid && rd_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Only committed beats are visible
    assign rd_valid = (rd_ptr != cm_ptr);
    assign rd_data  = mem_data[rd_ptr[aw-1:0]];
    assign rd_keep  = mem_keep[rd_ptr[aw-1:0]];
    assign rd_last  = mem_last[rd_ptr[aw-1:0]];

    a_rd_behind_commit: assert property (@(posedge clk) disable iff (!rst_n)
        cm_fill <= (aw+1)'(depth));

    // Overflow follows a finished drop with the partial packet already forgotten
    a_overflow_rewound: assert property (@(posedge clk) disable iff (!rst_n)
        overflow |-> !dropping && wr_ptr == cm_ptr);

    // A second pulse in a row needs another packet that met a full buffer
    a_overflow_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        overflow |=> !overflow || $past(full));

endmodule

//--- p4_ingress_width_adapt.sv
/* Packs 1- or 4-byte port beats into converged beats. The input cannot be stalled,
   and a partial keep is only legal on the beat that carries last. */

`timescale 1ns/1ns
`include "p4_ingress_defs.svh"

module p4_ingress_width_adapt
    import p4_ingress_pkg::*;
#(
    parameter int in_bytes = 1
) (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                in_valid,
    input  logic [in_bytes*8-1:0] in_data,
    input  logic [in_bytes-1:0] in_keep,
    input  logic                in_last,

    output logic                beat_valid,
    output p4_beat_u            beat_data,
    output p4_keep_t            beat_keep,
    output logic                beat_last
);

    localparam int lanes  = `P4_ING_BUS_BYTES / in_bytes;
    localparam int lane_w = $clog2(lanes);

    logic [lane_w-1:0] lane_cnt;
    p4_beat_u          acc_data;
    p4_keep_t          acc_keep;
    p4_beat_u          base_data;
    p4_beat_u          nxt_data;
    p4_keep_t          nxt_keep;
    logic              emit;

    //////////////////////////////////////////////////////////////////////
    // Lane merge

    // A fresh beat starts from zero so unused lanes never carry stale bytes
    assign base_data = (lane_cnt == '0) ? '0 : acc_data;
    assign emit      = in_valid && (in_last || lane_cnt == lane_w'(lanes - 1));

    generate
        if (in_bytes == 1) begin : g_byte_lanes
            always_comb begin
                nxt_data = base_data;
                nxt_data.bytes[lane_cnt] = in_data;
            end
        end else begin : g_word_lanes
            always_comb begin
                nxt_data = base_data;
                nxt_data.words[lane_cnt] = in_data;
            end
        end
    endgenerate

    always_comb begin
        nxt_keep = (lane_cnt == '0) ? '0 : acc_keep;
        nxt_keep[lane_cnt*in_bytes +: in_bytes] = in_keep;
    end

    //////////////////////////////////////////////////////////////////////
    // Accumulator and output register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_cnt   <= '0;
            acc_keep   <= '0;
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= emit;
            if (emit) begin
                lane_cnt <= '0;
                acc_keep <= '0;
            end else if (in_valid) begin
                lane_cnt <= lane_cnt + 1'b1;
                acc_keep <= nxt_keep;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            acc_data <= nxt_data;
        end
        if (emit) begin
            beat_data <= nxt_data;
            beat_keep <= nxt_keep;
            beat_last <= in_last;
        end
    end

    // Only the closing beat of a packet may leave lanes empty
    a_full_keep_mid_packet: assert property (@(posedge clk) disable iff (!rst_n)
        beat_valid && !beat_last |-> &beat_keep);

endmodule

//--- p4_ingress_pkg.sv
/* Types shared by the ingress blocks. Lane 0 of either view holds the first
   bytes received on the physical port. */

`include "p4_ingress_defs.svh"

package p4_ingress_pkg;

    // One converged data word, seen as byte lanes or as 32-bit word lanes
    typedef union packed {
        logic [`P4_ING_BUS_BYTES-1:0][7:0]    bytes;
        logic [`P4_ING_BUS_BYTES/4-1:0][31:0] words;
    } p4_beat_u;

    // Byte-valid mask, bit n covers byte lane n
    typedef logic [`P4_ING_BUS_BYTES-1:0] p4_keep_t;

    // Source port index carried on tuser
    typedef logic [$clog2(`P4_ING_NUM_PORTS)-1:0] p4_port_idx_t;

endpackage

//--- p4_ingress_defs.svh
/* Sizing of the ingress subsystem. The 8-bit ports take the lowest indices and the
   32-bit port follows them; the buffer depth must be a power of two. */

`ifndef P4_INGRESS_DEFS_SVH
`define P4_INGRESS_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Physical ports

// Narrow ports, one byte per beat
`define P4_ING_NUM_8B_PORTS   2

// Wide ports, one 32-bit word per beat
`define P4_ING_NUM_32B_PORTS  1

// Total count, also the number of arbiter inputs
`define P4_ING_NUM_PORTS      3

//////////////////////////////////////////////////////////////////////
// Converged bus and buffering

`define P4_ING_BUS_BYTES      8

// Entries are converged beats, not bytes
`define P4_ING_BUF_DEPTH      16

`endif
